// File: source/alu_pkg.sv
`default_nettype none

package alu_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CTRL_W     = 4;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;
    localparam int SHAMT_W    = $clog2(DATA_W);   // Shifts use the low bits of sr1 only.

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [CTRL_W-1:0]     alu_ctrl_t;

    // ALU control codes. Code 11 and above select no operation and give zero.
    localparam alu_ctrl_t CTRL_ALU_ADD  = 4'd0;
    localparam alu_ctrl_t CTRL_ALU_SUB  = 4'd1;
    localparam alu_ctrl_t CTRL_ALU_SLT  = 4'd2;
    localparam alu_ctrl_t CTRL_ALU_SLTU = 4'd3;
    localparam alu_ctrl_t CTRL_ALU_AND  = 4'd4;
    localparam alu_ctrl_t CTRL_ALU_OR   = 4'd5;
    localparam alu_ctrl_t CTRL_ALU_NOR  = 4'd6;
    localparam alu_ctrl_t CTRL_ALU_XOR  = 4'd7;
    localparam alu_ctrl_t CTRL_ALU_SLL  = 4'd8;
    localparam alu_ctrl_t CTRL_ALU_SRL  = 4'd9;
    localparam alu_ctrl_t CTRL_ALU_SRA  = 4'd10;

    typedef struct packed {
        alu_ctrl_t ctrl;
        reg_addr_t rd;
        reg_addr_t rs0;
        reg_addr_t rs1;
        logic      use_imm;   // Immediate replaces rs1 when set.
        data_t     imm;
    } dispatch_t;

    typedef struct packed {
        alu_ctrl_t ctrl;
        reg_addr_t rd;
        data_t     sr0;
        data_t     sr1;
    } alu_uop_t;

    typedef struct packed {
        reg_addr_t rd;
        data_t     result;
    } wb_t;

endpackage

`default_nettype wire

// File: source/operand_read.sv
`default_nettype none
`timescale 1ns/1ns

module operand_read import alu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      dispatch_valid,
    input  dispatch_t dispatch,
    output logic      dispatch_ready,
    input  logic      queue_full,
    output logic      push,
    output alu_uop_t  push_uop,
    input  logic      wb_en,
    input  wb_t       wb
);

    data_t               regs [NUM_REGS];
    logic [NUM_REGS-1:0] busy;   // One bit per register with a result in flight.
    data_t               rs0_data;
    data_t               rs1_data;
    logic                rs0_stall;
    logic                rs1_stall;
    logic                rd_stall;
    logic                rd_nonzero;

    // Register 0 reads as zero whatever the array holds.
    assign rs0_data = (dispatch.rs0 == '0) ? '0 : regs[dispatch.rs0];
    assign rs1_data = (dispatch.rs1 == '0) ? '0 : regs[dispatch.rs1];

    assign rd_nonzero = (dispatch.rd != '0);

    // Bit 0 of the scoreboard is never set, so register 0 never stalls.
    assign rs0_stall = busy[dispatch.rs0];
    assign rs1_stall = busy[dispatch.rs1] && !dispatch.use_imm;
    assign rd_stall  = busy[dispatch.rd];

    assign dispatch_ready = !queue_full && !rs0_stall && !rs1_stall && !rd_stall;
    assign push           = dispatch_valid && dispatch_ready;

    always_comb begin
        push_uop.ctrl = dispatch.ctrl;
        push_uop.rd   = dispatch.rd;
        push_uop.sr0  = rs0_data;
        push_uop.sr1  = dispatch.use_imm ? dispatch.imm : rs1_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.result;   // Writes to register 0 are dropped.
        end
    end

    // A pushed rd is never busy and a written-back rd always is, so the two never collide.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (wb_en) begin
                busy[wb.rd] <= 1'b0;
            end
            if (push && rd_nonzero) begin
                busy[dispatch.rd] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/uop_queue.sv
`default_nettype none
`timescale 1ns/1ns

module uop_queue import alu_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  alu_uop_t push_uop,
    output logic     full,
    output logic     pop_valid,
    output alu_uop_t pop_uop
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    alu_uop_t         mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    // Wraps at the depth, so depths that are not a power of two work too.
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(QUEUE_DEPTH));
    assign pop_valid = (count != '0);
    assign pop       = pop_valid;   // The ALU takes the head on every valid cycle.
    assign pop_uop   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_uop;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/alu.sv
`default_nettype none
`timescale 1ns/1ns

module alu import alu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     alu_en_in,
    input  alu_uop_t alu_uop,
    output logic     wb_en,
    output wb_t      wb
);

    logic  op_add;
    logic  op_sub;
    logic  op_slt;
    logic  op_sltu;
    logic  op_and;
    logic  op_or;
    logic  op_nor;
    logic  op_xor;
    logic  op_sll;
    logic  op_srl;
    logic  op_sra;
    logic  sub_mode;
    data_t adder_b;
    data_t adder_result;
    logic  adder_cout;
    logic  slt_bit;
    logic  sltu_bit;
    data_t result;

    assign op_add  = (alu_uop.ctrl == CTRL_ALU_ADD);
    assign op_sub  = (alu_uop.ctrl == CTRL_ALU_SUB);
    assign op_slt  = (alu_uop.ctrl == CTRL_ALU_SLT);
    assign op_sltu = (alu_uop.ctrl == CTRL_ALU_SLTU);
    assign op_and  = (alu_uop.ctrl == CTRL_ALU_AND);
    assign op_or   = (alu_uop.ctrl == CTRL_ALU_OR);
    assign op_nor  = (alu_uop.ctrl == CTRL_ALU_NOR);
    assign op_xor  = (alu_uop.ctrl == CTRL_ALU_XOR);
    assign op_sll  = (alu_uop.ctrl == CTRL_ALU_SLL);
    assign op_srl  = (alu_uop.ctrl == CTRL_ALU_SRL);
    assign op_sra  = (alu_uop.ctrl == CTRL_ALU_SRA);

    // Subtract and both compares share the adder as sr0 + ~sr1 + 1.
    assign sub_mode = op_sub | op_slt | op_sltu;
    assign adder_b  = sub_mode ? ~alu_uop.sr1 : alu_uop.sr1;
    assign {adder_cout, adder_result} = {1'b0, alu_uop.sr0} + {1'b0, adder_b}
                                        + {{DATA_W{1'b0}}, sub_mode};

    // A negative sr0 wins when the signs differ and the difference sign decides otherwise.
    assign slt_bit  = (alu_uop.sr0[DATA_W-1] & ~alu_uop.sr1[DATA_W-1])
                    | (~(alu_uop.sr0[DATA_W-1] ^ alu_uop.sr1[DATA_W-1]) & adder_result[DATA_W-1]);
    assign sltu_bit = ~adder_cout;   // No carry out means a borrow.

    assign result = ({DATA_W{op_add | op_sub}} & adder_result)
                  | ({DATA_W{op_slt}}  & data_t'(slt_bit))
                  | ({DATA_W{op_sltu}} & data_t'(sltu_bit))
                  | ({DATA_W{op_and}}  & (alu_uop.sr0 & alu_uop.sr1))
                  | ({DATA_W{op_or}}   & (alu_uop.sr0 | alu_uop.sr1))
                  | ({DATA_W{op_nor}}  & ~(alu_uop.sr0 | alu_uop.sr1))
                  | ({DATA_W{op_xor}}  & (alu_uop.sr0 ^ alu_uop.sr1))
                  | ({DATA_W{op_sll}}  & (alu_uop.sr0 << alu_uop.sr1[SHAMT_W-1:0]))
                  | ({DATA_W{op_srl}}  & (alu_uop.sr0 >> alu_uop.sr1[SHAMT_W-1:0]))
                  | ({DATA_W{op_sra}}  & data_t'($signed(alu_uop.sr0) >>> alu_uop.sr1[SHAMT_W-1:0]));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= alu_en_in;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_en_in) begin
            wb.rd     <= alu_uop.rd;
            wb.result <= result;
        end
    end

endmodule

`default_nettype wire

// File: source/alu_cluster.sv
`default_nettype none
`timescale 1ns/1ns

module alu_cluster import alu_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      dispatch_valid,
    input  dispatch_t dispatch,
    output logic      dispatch_ready,
    output logic      wb_en,
    output wb_t       wb
);

    logic     queue_full;
    logic     push;
    alu_uop_t push_uop;
    logic     pop_valid;
    alu_uop_t pop_uop;

    // The writeback port also feeds the register file and scoreboard.
    operand_read operand_read_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .queue_full     (queue_full),
        .push           (push),
        .push_uop       (push_uop),
        .wb_en          (wb_en),
        .wb             (wb)
    );

    uop_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) uop_queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_uop  (push_uop),
        .full      (queue_full),
        .pop_valid (pop_valid),
        .pop_uop   (pop_uop)
    );

    alu alu_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .alu_en_in (pop_valid),
        .alu_uop   (pop_uop),
        .wb_en     (wb_en),
        .wb        (wb)
    );

endmodule

`default_nettype wire

// File: tests/alu_cluster_asserts.sv
`default_nettype none
`timescale 1ns/1ns

module alu_cluster_asserts import alu_pkg::*; (
    input logic                clk,
    input logic                rst_n,
    input logic                dispatch_valid,
    input logic                dispatch_ready,
    input dispatch_t           dispatch,
    input logic                push,
    input logic                queue_full,
    input logic                pop_valid,
    input logic                wb_en,
    input logic [NUM_REGS-1:0] busy
);

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(push && queue_full))
        else $error("push into a full micro-op queue");

    wb_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !wb_en)
        else $error("wb_en high in the first cycle after reset");

    // Register 0 is never busy, so it needs no special case here.
    no_busy_source: assert property (@(posedge clk) disable iff (!rst_n)
        (dispatch_valid && dispatch_ready) |->
            (!busy[dispatch.rs0] && (dispatch.use_imm || !busy[dispatch.rs1])))
        else $error("dispatch accepted with a busy source register");

    wb_follows_pop: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |-> $past(pop_valid))
        else $error("writeback without a queue pop in the previous cycle");

endmodule

bind alu_cluster alu_cluster_asserts alu_cluster_asserts_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .dispatch       (dispatch),
    .push           (push),
    .queue_full     (queue_full),
    .pop_valid      (pop_valid),
    .wb_en          (wb_en),
    .busy           (operand_read_i.busy)
);

`default_nettype wire

// File: tests/alu_cluster_tb.sv
`default_nettype none
`timescale 1ns/1ns

module alu_cluster_tb import alu_pkg::*; ();

    localparam int    QUEUE_DEPTH  = 4;
    localparam int    NUM_PATTERNS = 50;
    localparam int    RESET_CYCLES = 16;
    localparam int    CLK_PERIOD   = 10;
    localparam int    CHAIN_FIRST  = 35;   // The chain and the burst go out with no gaps.
    localparam int    BURST_FIRST  = 41;
    localparam int    BURST_LAST   = 48;
    localparam int    SEED         = 40;
    localparam string PATTERN_FILE = "tests/alu_cluster_patterns.hex";

    logic      clk;
    logic      rst_n;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      dispatch_ready;
    logic      wb_en;
    wb_t       wb;

    dispatch_t   patterns [NUM_PATTERNS];
    data_t       model_regs [NUM_REGS];
    wb_t         expected_q [$];
    logic [31:0] lcg_state;
    logic        accepted;
    int          errors;
    int          checks;
    int          wb_count;
    int          burst_stalls;
    int          cur_idx;

    alu_cluster #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) alu_cluster_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .wb_en          (wb_en),
        .wb             (wb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int next_gap();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) % 32'd4);   // Gap of 0 to 3 cycles.
    endfunction

    function automatic data_t model_alu(input alu_ctrl_t ctrl, input data_t a, input data_t b);
        logic [4:0] shamt;
        shamt = b[4:0];
        case (ctrl)
            CTRL_ALU_ADD:  return a + b;
            CTRL_ALU_SUB:  return a - b;
            CTRL_ALU_SLT:  return {{(DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            CTRL_ALU_SLTU: return {{(DATA_W-1){1'b0}}, a < b};
            CTRL_ALU_AND:  return a & b;
            CTRL_ALU_OR:   return a | b;
            CTRL_ALU_NOR:  return ~(a | b);
            CTRL_ALU_XOR:  return a ^ b;
            CTRL_ALU_SLL:  return a << shamt;
            CTRL_ALU_SRL:  return a >> shamt;
            CTRL_ALU_SRA:  return data_t'($signed(a) >>> shamt);
            default:       return '0;
        endcase
    endfunction

    // Architectural state advances in dispatch order, which is also writeback order.
    task automatic record_dispatch(input dispatch_t d);
        data_t a;
        data_t b;
        wb_t   exp_wb;
        a = (d.rs0 == '0) ? '0 : model_regs[d.rs0];
        b = d.use_imm ? d.imm : ((d.rs1 == '0) ? '0 : model_regs[d.rs1]);
        exp_wb.rd     = d.rd;
        exp_wb.result = model_alu(d.ctrl, a, b);
        expected_q.push_back(exp_wb);
        if (d.rd != '0) begin
            model_regs[d.rd] = exp_wb.result;
        end
    endtask

    task automatic check_writeback();
        wb_t exp_wb;
        wb_count++;
        checks++;
        if (expected_q.size() == 0) begin
            errors++;
            $display("** Error at %0t: writeback to r%0d with no micro-op outstanding",
                     $time, wb.rd);
        end else begin
            exp_wb = expected_q.pop_front();
            if (wb.rd !== exp_wb.rd) begin
                errors++;
                $display("** Error at %0t: wb.rd = %0d, expected %0d", $time, wb.rd, exp_wb.rd);
            end
            checks++;
            if (wb.result !== exp_wb.result) begin
                errors++;
                $display("** Error at %0t: wb.result = 0x%08h, expected 0x%08h",
                         $time, wb.result, exp_wb.result);
            end
        end
    endtask

    // Values are taken before the edge updates any DUT register.
    always @(posedge clk) begin
        accepted <= dispatch_valid && dispatch_ready;
        if (rst_n) begin
            if (wb_en) begin
                check_writeback();
            end
            if (dispatch_valid && dispatch_ready) begin
                record_dispatch(dispatch);
            end
            if (dispatch_valid && !dispatch_ready && cur_idx >= BURST_FIRST
                    && cur_idx <= BURST_LAST) begin
                burst_stalls++;
            end
        end
    end

    task automatic check_idle_state(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            checks++;
            if (wb_en !== 1'b0) begin
                errors++;
                $display("** Error at %0t: wb_en = %b, expected 0", $time, wb_en);
            end
            checks++;
            if (dispatch_ready !== 1'b1) begin
                errors++;
                $display("** Error at %0t: dispatch_ready = %b, expected 1", $time, dispatch_ready);
            end
        end
    endtask

    // Called on a falling edge. Returns on the falling edge after the transfer.
    task automatic send_uop(input dispatch_t d);
        dispatch       = d;
        dispatch_valid = 1'b1;
        @(negedge clk);
        while (!accepted) begin
            @(negedge clk);
        end
        dispatch_valid = 1'b0;
    endtask

    task automatic final_checks();
        checks++;
        if (wb_count != NUM_PATTERNS) begin
            errors++;
            $display("Writeback count is %0d but %0d micro-ops were dispatched",
                     wb_count, NUM_PATTERNS);
        end
        checks++;
        if (expected_q.size() != 0) begin
            errors++;
            $display("%0d expected writebacks never arrived", expected_q.size());
        end
        checks++;
        if (burst_stalls == 0) begin
            errors++;
            $display("dispatch_ready never dropped during the zero-gap burst");
        end
    endtask

    initial begin
        int gap;
        clk            = 1'b0;
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        accepted       = 1'b0;
        errors         = 0;
        checks         = 0;
        wb_count       = 0;
        burst_stalls   = 0;
        cur_idx        = 0;
        lcg_state      = SEED;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        $readmemh(PATTERN_FILE, patterns);
        if ($isunknown(patterns[NUM_PATTERNS-1])) begin
            errors++;
            $display("Pattern file %s did not load completely", PATTERN_FILE);
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        check_idle_state(4);
        for (int i = 0; i < NUM_PATTERNS; i++) begin
            cur_idx = i;
            gap = (i >= CHAIN_FIRST && i <= BURST_LAST) ? 0 : next_gap();
            repeat (gap) @(negedge clk);
            send_uop(patterns[i]);
        end
        while (wb_count < NUM_PATTERNS) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);   // A duplicate writeback would show up here.
        final_checks();
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        repeat (NUM_PATTERNS * 20 + RESET_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with %0d of %0d writebacks seen",
                 NUM_PATTERNS * 20 + RESET_CYCLES, wb_count, NUM_PATTERNS);
        $display("errors: %0d, checks: %0d", errors + 1, checks);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/alu_cluster_patterns.hex
// One dispatch_t per line: upper 5 hex digits {ctrl, rd, rs0, rs1, use_imm}, then imm.
// Upper field = ctrl*0x10000 + rd*0x800 + rs0*0x40 + rs1*2 + use_imm.
// Load operands through immediates.
00801_80000000  // add  r1, r0, #0x80000000
01001_00000001  // add  r2, r0, #1
01801_12345678  // add  r3, r0, #0x12345678
02001_F0F0F0F0  // add  r4, r0, #0xF0F0F0F0
02801_FFFFFFFF  // add  r5, r0, #0xFFFFFFFF
// Register forms; the immediate is ignored.
030C8_DEADBEEF  // add  r6, r3, r4
138C4_00000000  // sub  r7, r3, r2
24044_00000000  // slt  r8, r1, r2
34844_00000000  // sltu r9, r1, r2
25082_00000000  // slt  r10, r2, r1
35882_00000000  // sltu r11, r2, r1
260C6_00000000  // slt  r12, r3, r3
3694A_00000000  // sltu r13, r5, r5
470C8_00000000  // and  r14, r3, r4
578C8_00000000  // or   r15, r3, r4
680C8_00000000  // nor  r16, r3, r4
788C8_00000000  // xor  r17, r3, r4
// Shifts, including amounts with upper bits set.
890C1_00000000  // sll  r18, r3, #0
89881_0000001F  // sll  r19, r2, #31
9A041_0000001F  // srl  r20, r1, #31
AA841_0000001F  // sra  r21, r1, #31
AB101_00000000  // sra  r22, r4, #0
8B8C1_FFFFFFE4  // sll  r23, r3, #0xFFFFFFE4
9C141_00000123  // srl  r24, r5, #0x123
AC901_7FFFFFE8  // sra  r25, r4, #0x7FFFFFE8
9D148_00000000  // srl  r26, r5, r4
// Unused codes and immediate forms.
BD8C8_00000000  // code 11 r27, r3, r4
FE141_FFFFFFFF  // code 15 r28, r5, #0xFFFFFFFF
1E801_00000001  // sub  r29, r0, #1
7F141_0F0F0F0F  // xor  r30, r5, #0x0F0F0F0F
// Register 0 as destination and source.
000C8_00000000  // add  r0, r3, r4
5F800_00000000  // or   r31, r0, r0
00001_55555555  // add  r0, r0, #0x55555555
0F806_00000000  // add  r31, r0, r3
1F8C0_00000000  // sub  r31, r3, r0
// Dependent chain.
03001_00000001  // add  r6, r0, #1
03181_00000001  // add  r6, r6, #1
83981_00000003  // sll  r7, r6, #3
041CC_00000000  // add  r8, r7, r6
1320E_00000000  // sub  r6, r8, r7
74990_00000000  // xor  r9, r6, r8
// Burst that alternates destinations r10 and r11.
05001_00000011  // add  r10, r0, #0x11
05801_00000022  // add  r11, r0, #0x22
15081_00000005  // sub  r10, r2, #5
558C1_0000FF00  // or   r11, r3, #0xFF00
45141_00FF00FF  // and  r10, r5, #0x00FF00FF
65801_00000000  // nor  r11, r0, #0
25041_00000000  // slt  r10, r1, #0
35881_FFFFFFFF  // sltu r11, r2, #0xFFFFFFFF
06296_00000000  // add  r12, r10, r11

// File: alu_cluster.f
source/alu_pkg.sv
source/operand_read.sv
source/uop_queue.sv
source/alu.sv
source/alu_cluster.sv
tests/alu_cluster_asserts.sv
tests/alu_cluster_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = alu_cluster_tb
FILELIST = alu_cluster.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = === FAIL ===
PASS_MSG = === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -- "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q -- "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
